// File: common/md_filter_params.svh
// MD pair filter parameters for widths, box geometry, cutoff, buffering and pipeline timing
`ifndef MD_FILTER_PARAMS_SVH
`define MD_FILTER_PARAMS_SVH

// Fixed point coordinate and derived widths
`define COORD_W 12
`define DIST_W 13
`define R2_W 26
`define ID_W 8

// Periodic box edges in coordinate units
`define BOX_X 3000
`define BOX_Y 2500
`define BOX_Z 2500

// Squared cutoff, radius 500
`define CUTOFF2 250000

// Per lane pair buffer
`define BUF_DEPTH 16
`define BUF_AW 4

// Stages in the r2 pipeline
`define R2_LATENCY 4
// Covers pipeline, filter register, bp register and source reaction
`define BP_THRESHOLD (`R2_LATENCY + 3)

`endif

// File: common/md_filter_pkg.sv
// MD pair filter package with coordinate, id, pair record and arbiter state types
`include "md_filter_params.svh"

package md_filter_pkg;

	////////////////////////////////
	// Scalar types
	////////////////////////////////

	// Unsigned fixed point coordinate
	typedef logic [`COORD_W-1:0] coord_t;

	// Signed displacement, one bit wider than a coordinate
	typedef logic signed [`DIST_W-1:0] dist_t;

	// Particle id
	typedef logic [`ID_W-1:0] pair_id_t;

	////////////////////////////////
	// Buffer word
	////////////////////////////////

	// MSB to LSB as stored in the lane buffer
	typedef struct packed {
		pair_id_t          ref_id;
		pair_id_t          nbr_id;
		logic [`R2_W-1:0]  r2;
		dist_t             dz;
		dist_t             dy;
		dist_t             dx;
	} pair_rec_t;

	// Which lane wins when both have a pair
	typedef enum logic {
		GRANT_LANE0,
		GRANT_LANE1
	} grant_e;

endpackage

// File: common/pair_if.sv
// Pair stream link carrying one filtered pair with valid/ready handshake
`timescale 1ns/10ps

interface pair_if;

	// Handshake
	logic valid;
	logic ready;

	// Payload, held stable while valid waits for ready
	md_filter_pkg::pair_rec_t rec;

	// Lane side
	modport source (
		output valid,
		output rec,
		input  ready
	);

	// Arbiter side
	modport sink (
		input  valid,
		input  rec,
		output ready
	);

endinterface

// File: filter/r2_pbc_compute.sv
// Four stage periodic displacement and squared distance pipeline for one pair
`timescale 1ns/10ps
`include "md_filter_params.svh"

module r2_pbc_compute (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	input  md_filter_pkg::coord_t  ref_x,
	input  md_filter_pkg::coord_t  ref_y,
	input  md_filter_pkg::coord_t  ref_z,
	input  md_filter_pkg::coord_t  nbr_x,
	input  md_filter_pkg::coord_t  nbr_y,
	input  md_filter_pkg::coord_t  nbr_z,
	output logic                   r2_valid,
	output logic [`R2_W-1:0]       r2,
	output md_filter_pkg::dist_t   dx,
	output md_filter_pkg::dist_t   dy,
	output md_filter_pkg::dist_t   dz
);

	// Fold a raw difference back into the nearest image
	function automatic md_filter_pkg::dist_t pbc_wrap(input md_filter_pkg::dist_t d,
		input int box);
		if (int'(d) > box / 2)
			return d - md_filter_pkg::dist_t'(box);
		else if (int'(d) < -(box / 2))
			return d + md_filter_pkg::dist_t'(box);
		else
			return d;
	endfunction

	// True when a wrapped component lies within half the box
	function automatic logic in_half(input md_filter_pkg::dist_t d, input int box);
		return (int'(d) <= box / 2) && (int'(d) >= -(box / 2));
	endfunction

	// Valid shift chain, one bit per stage
	logic [`R2_LATENCY-1:0] vld;

	// Stage 1 raw differences
	md_filter_pkg::dist_t d1_x, d1_y, d1_z;
	// Stage 2 wrapped differences
	md_filter_pkg::dist_t d2_x, d2_y, d2_z;
	// Stage 3 squares, displacements ride along
	logic [`R2_W-1:0] sq_x, sq_y, sq_z;
	md_filter_pkg::dist_t d3_x, d3_y, d3_z;

	always_ff @(posedge clk)
	begin
		if (rst)
			vld <= '0;
		else
			vld <= {vld[`R2_LATENCY-2:0], in_valid};
	end

	////////////////////////////////
	// Datapath
	////////////////////////////////
	always_ff @(posedge clk)
	begin
		// Neighbor minus reference, zero extended into signed
		d1_x <= $signed({1'b0, nbr_x}) - $signed({1'b0, ref_x});
		d1_y <= $signed({1'b0, nbr_y}) - $signed({1'b0, ref_y});
		d1_z <= $signed({1'b0, nbr_z}) - $signed({1'b0, ref_z});
		// Minimum image
		d2_x <= pbc_wrap(d1_x, `BOX_X);
		d2_y <= pbc_wrap(d1_y, `BOX_Y);
		d2_z <= pbc_wrap(d1_z, `BOX_Z);
		// Signed square is never negative, 26 bits hold it
		sq_x <= d2_x * d2_x;
		sq_y <= d2_y * d2_y;
		sq_z <= d2_z * d2_z;
		d3_x <= d2_x;
		d3_y <= d2_y;
		d3_z <= d2_z;
		// Sum, bounded well below 2^26 after wrap
		r2 <= sq_x + sq_y + sq_z;
		dx <= d3_x;
		dy <= d3_y;
		dz <= d3_z;
	end

	assign r2_valid = vld[`R2_LATENCY-1];

	// Coordinates inside the box always fold to within half an edge
	assert property (@(posedge clk) disable iff (rst)
		vld[1] |-> (in_half(d2_x, `BOX_X) && in_half(d2_y, `BOX_Y) && in_half(d2_z, `BOX_Z)))
		else $error("wrapped displacement exceeds half box");

	// Fixed latency from accept to r2
	assert property (@(posedge clk) disable iff (rst)
		r2_valid == $past(in_valid, `R2_LATENCY))
		else $error("r2_valid out of step with in_valid");

endmodule

// File: filter/pair_buffer.sv
// Pair buffer, first word fall through FIFO of filtered pair records with fill count
`timescale 1ns/10ps
`include "md_filter_params.svh"

module pair_buffer (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      wr,
	input  md_filter_pkg::pair_rec_t  wr_rec,
	input  logic                      rd,
	output md_filter_pkg::pair_rec_t  rd_rec,
	output logic                      empty,
	output logic [`BUF_AW:0]          used
);

	// Storage, payload only
	md_filter_pkg::pair_rec_t mem [`BUF_DEPTH];

	// Pointers wrap on their own since depth is a power of two
	logic [`BUF_AW-1:0] wr_ptr;
	logic [`BUF_AW-1:0] rd_ptr;
	logic               full;

	assign empty = (used == '0);
	assign full  = (used == (`BUF_AW+1)'(`BUF_DEPTH));

	// Head entry shows without a read
	assign rd_rec = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (wr)
			mem[wr_ptr] <= wr_rec;
	end

	////////////////////////////////
	// Pointers and count
	////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end
		else
		begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous read and write leaves the count alone
			if (wr && !rd)
				used <= used + 1'b1;
			else if (rd && !wr)
				used <= used - 1'b1;
		end
	end

	// Upstream back-pressure must keep the buffer from overflowing
	assert property (@(posedge clk) disable iff (rst) !(wr && full))
		else $error("pair buffer overflow");

	assert property (@(posedge clk) disable iff (rst) !(rd && empty))
		else $error("pair buffer underflow");

endmodule

// File: filter/pair_filter.sv
// Pair filter lane, r2 compute, id delay, cutoff test, buffering and back-pressure
`timescale 1ns/10ps
`include "md_filter_params.svh"

module pair_filter (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      in_valid,
	input  md_filter_pkg::pair_id_t   ref_id,
	input  md_filter_pkg::pair_id_t   nbr_id,
	input  md_filter_pkg::coord_t     ref_x,
	input  md_filter_pkg::coord_t     ref_y,
	input  md_filter_pkg::coord_t     ref_z,
	input  md_filter_pkg::coord_t     nbr_x,
	input  md_filter_pkg::coord_t     nbr_y,
	input  md_filter_pkg::coord_t     nbr_z,
	output logic                      bp,
	pair_if.source                    pair_out
);

	// Pipeline results
	logic                  r2_valid;
	logic [`R2_W-1:0]      r2;
	md_filter_pkg::dist_t  dx, dy, dz;

	// Ids delayed to line up with r2
	md_filter_pkg::pair_id_t ref_dly [`R2_LATENCY];
	md_filter_pkg::pair_id_t nbr_dly [`R2_LATENCY];

	// Filter register feeding the buffer
	logic                      buf_wr;
	md_filter_pkg::pair_rec_t  buf_rec;

	// Buffer status and read side
	logic               buf_empty;
	logic [`BUF_AW:0]   buf_used;
	logic               buf_rd;

	r2_pbc_compute u_r2 (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.ref_x    (ref_x),
		.ref_y    (ref_y),
		.ref_z    (ref_z),
		.nbr_x    (nbr_x),
		.nbr_y    (nbr_y),
		.nbr_z    (nbr_z),
		.r2_valid (r2_valid),
		.r2       (r2),
		.dx       (dx),
		.dy       (dy),
		.dz       (dz)
	);

	// Id delay line, same depth as the r2 pipeline
	always_ff @(posedge clk)
	begin
		ref_dly[0] <= ref_id;
		nbr_dly[0] <= nbr_id;
		for (int i = 1; i < `R2_LATENCY; i++)
		begin
			ref_dly[i] <= ref_dly[i-1];
			nbr_dly[i] <= nbr_dly[i-1];
		end
	end

	////////////////////////////////
	// Cutoff filter
	////////////////////////////////
	// Keep r2 within cutoff, drop self pairs at r2 of zero
	always_ff @(posedge clk)
	begin
		if (rst)
			buf_wr <= 1'b0;
		else
			buf_wr <= r2_valid && (r2 <= `R2_W'(`CUTOFF2)) && (r2 != '0);
	end

	always_ff @(posedge clk)
	begin
		buf_rec <= '{ref_id: ref_dly[`R2_LATENCY-1], nbr_id: nbr_dly[`R2_LATENCY-1],
			r2: r2, dz: dz, dy: dy, dx: dx};
	end

	pair_buffer u_buf (
		.clk    (clk),
		.rst    (rst),
		.wr     (buf_wr),
		.wr_rec (buf_rec),
		.rd     (buf_rd),
		.rd_rec (pair_out.rec),
		.empty  (buf_empty),
		.used   (buf_used)
	);

	// Lane handshake straight off the buffer head
	assign pair_out.valid = !buf_empty;
	assign buf_rd         = pair_out.valid && pair_out.ready;

	// Raise bp while too few entries remain for pairs still in flight
	always_ff @(posedge clk)
	begin
		if (rst)
			bp <= 1'b0;
		else
			bp <= (`BUF_DEPTH - int'(buf_used)) < `BP_THRESHOLD;
	end

endmodule

// File: logic/pair_arbiter.sv
// Pair arbiter, round-robin merge of two lane streams into one output stream
`timescale 1ns/10ps

module pair_arbiter (
	input  logic                      clk,
	input  logic                      rst,
	pair_if.sink                      lane0,
	pair_if.sink                      lane1,
	output logic                      out_valid,
	input  logic                      out_ready,
	output logic                      out_lane,
	output md_filter_pkg::pair_rec_t  out_rec
);

	// Lane favored on the next contention
	md_filter_pkg::grant_e prio;

	// Lane 1 wins when alone or when favored
	logic sel1;

	assign sel1 = lane1.valid && (!lane0.valid || prio == md_filter_pkg::GRANT_LANE1);

	////////////////////////////////
	// Output mux and handshake
	////////////////////////////////
	assign out_valid   = lane0.valid || lane1.valid;
	assign out_lane    = sel1;
	assign out_rec     = sel1 ? lane1.rec : lane0.rec;
	assign lane0.ready = out_ready && lane0.valid && !sel1;
	assign lane1.ready = out_ready && sel1;

	// Priority flips away from whichever lane just moved a pair
	always_ff @(posedge clk)
	begin
		if (rst)
			prio <= md_filter_pkg::GRANT_LANE0;
		else if (out_valid && out_ready)
			prio <= sel1 ? md_filter_pkg::GRANT_LANE0 : md_filter_pkg::GRANT_LANE1;
	end

	// Only one lane buffer may be popped per transfer
	assert property (@(posedge clk) disable iff (rst) !(lane0.ready && lane1.ready))
		else $error("both lanes granted at once");

endmodule

// File: logic/md_filter_bank.sv
// MD filter bank top level, two pair filter lanes merged by a round-robin arbiter
`timescale 1ns/10ps
`include "md_filter_params.svh"

module md_filter_bank (
	input  logic                     clk,
	input  logic                     rst,
	// Lane 0 input
	input  logic                     lane0_valid,
	input  md_filter_pkg::pair_id_t  lane0_ref_id,
	input  md_filter_pkg::pair_id_t  lane0_nbr_id,
	input  md_filter_pkg::coord_t    lane0_ref_x,
	input  md_filter_pkg::coord_t    lane0_ref_y,
	input  md_filter_pkg::coord_t    lane0_ref_z,
	input  md_filter_pkg::coord_t    lane0_nbr_x,
	input  md_filter_pkg::coord_t    lane0_nbr_y,
	input  md_filter_pkg::coord_t    lane0_nbr_z,
	output logic                     lane0_bp,
	// Lane 1 input
	input  logic                     lane1_valid,
	input  md_filter_pkg::pair_id_t  lane1_ref_id,
	input  md_filter_pkg::pair_id_t  lane1_nbr_id,
	input  md_filter_pkg::coord_t    lane1_ref_x,
	input  md_filter_pkg::coord_t    lane1_ref_y,
	input  md_filter_pkg::coord_t    lane1_ref_z,
	input  md_filter_pkg::coord_t    lane1_nbr_x,
	input  md_filter_pkg::coord_t    lane1_nbr_y,
	input  md_filter_pkg::coord_t    lane1_nbr_z,
	output logic                     lane1_bp,
	// Merged pair stream toward the force pipeline
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic                     out_lane,
	output md_filter_pkg::pair_id_t  out_ref_id,
	output md_filter_pkg::pair_id_t  out_nbr_id,
	output logic [`R2_W-1:0]         out_r2,
	output md_filter_pkg::dist_t     out_dx,
	output md_filter_pkg::dist_t     out_dy,
	output md_filter_pkg::dist_t     out_dz
);

	// Lane to arbiter links
	pair_if lane0_link ();
	pair_if lane1_link ();

	md_filter_pkg::pair_rec_t out_rec;

	pair_filter u_lane0 (
		.clk (clk), .rst (rst), .in_valid (lane0_valid),
		.ref_id (lane0_ref_id), .nbr_id (lane0_nbr_id),
		.ref_x (lane0_ref_x), .ref_y (lane0_ref_y), .ref_z (lane0_ref_z),
		.nbr_x (lane0_nbr_x), .nbr_y (lane0_nbr_y), .nbr_z (lane0_nbr_z),
		.bp (lane0_bp), .pair_out (lane0_link.source)
	);

	pair_filter u_lane1 (
		.clk (clk), .rst (rst), .in_valid (lane1_valid),
		.ref_id (lane1_ref_id), .nbr_id (lane1_nbr_id),
		.ref_x (lane1_ref_x), .ref_y (lane1_ref_y), .ref_z (lane1_ref_z),
		.nbr_x (lane1_nbr_x), .nbr_y (lane1_nbr_y), .nbr_z (lane1_nbr_z),
		.bp (lane1_bp), .pair_out (lane1_link.source)
	);

	pair_arbiter u_arb (
		.clk       (clk),
		.rst       (rst),
		.lane0     (lane0_link.sink),
		.lane1     (lane1_link.sink),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_lane  (out_lane),
		.out_rec   (out_rec)
	);

	// Record fields out to plain ports
	assign out_ref_id = out_rec.ref_id;
	assign out_nbr_id = out_rec.nbr_id;
	assign out_r2     = out_rec.r2;
	assign out_dx     = out_rec.dx;
	assign out_dy     = out_rec.dy;
	assign out_dz     = out_rec.dz;

endmodule

// File: tb/md_filter_bank_tb.sv
// MD filter bank testbench, drives both lanes and scores the merged pair stream
`timescale 1ns/10ps
`include "md_filter_params.svh"

module md_filter_bank_tb;

	localparam int N_DIR  = 9;
	localparam int N_RAND = 200;
	localparam int N_BP   = 60;
	// Four clock periods per pair plus slack for reset and drain
	localparam longint TIMEOUT_NS = 8 * (N_DIR + 2 * N_RAND + 2 * N_BP) * 4 + 2000;

	logic clk;
	logic rst;
	logic                     valid_in [2];
	md_filter_pkg::pair_id_t  ref_id_in [2];
	md_filter_pkg::pair_id_t  nbr_id_in [2];
	md_filter_pkg::coord_t    ref_c [2][3];
	md_filter_pkg::coord_t    nbr_c [2][3];
	logic                     bp_out [2];
	logic                     out_valid, out_ready, out_lane;
	md_filter_pkg::pair_id_t  out_ref_id, out_nbr_id;
	logic [`R2_W-1:0]         out_r2;
	md_filter_pkg::dist_t     out_dx, out_dy, out_dz;

	// Expected pairs per lane, oldest first
	md_filter_pkg::pair_rec_t exp_q [2][$];
	md_filter_pkg::pair_rec_t head;
	int    errors;
	int    checked;
	string test_name;
	logic  alt_mode, have_prev, prev_lane, both_pending;
	logic  bp_seen [2];

	md_filter_bank DUT (
		.clk (clk), .rst (rst),
		.lane0_valid (valid_in[0]), .lane0_ref_id (ref_id_in[0]), .lane0_nbr_id (nbr_id_in[0]),
		.lane0_ref_x (ref_c[0][0]), .lane0_ref_y (ref_c[0][1]), .lane0_ref_z (ref_c[0][2]),
		.lane0_nbr_x (nbr_c[0][0]), .lane0_nbr_y (nbr_c[0][1]), .lane0_nbr_z (nbr_c[0][2]),
		.lane0_bp (bp_out[0]),
		.lane1_valid (valid_in[1]), .lane1_ref_id (ref_id_in[1]), .lane1_nbr_id (nbr_id_in[1]),
		.lane1_ref_x (ref_c[1][0]), .lane1_ref_y (ref_c[1][1]), .lane1_ref_z (ref_c[1][2]),
		.lane1_nbr_x (nbr_c[1][0]), .lane1_nbr_y (nbr_c[1][1]), .lane1_nbr_z (nbr_c[1][2]),
		.lane1_bp (bp_out[1]),
		.out_valid (out_valid), .out_ready (out_ready), .out_lane (out_lane),
		.out_ref_id (out_ref_id), .out_nbr_id (out_nbr_id), .out_r2 (out_r2),
		.out_dx (out_dx), .out_dy (out_dy), .out_dz (out_dz)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////
	// Reference model
	////////////////////////////////
	// Nearest image of one raw difference
	function automatic int wrap_dist(input int d, input int box);
		if (d > box / 2)
			return d - box;
		else if (d < -(box / 2))
			return d + box;
		return d;
	endfunction

	// Wrapped displacement and r2, returns true when the pair survives the filter
	function automatic logic ref_pair(input int rx, ry, rz, nx, ny, nz,
		output md_filter_pkg::pair_rec_t rec);
		int ddx, ddy, ddz;
		longint r2;
		ddx = wrap_dist(nx - rx, `BOX_X);
		ddy = wrap_dist(ny - ry, `BOX_Y);
		ddz = wrap_dist(nz - rz, `BOX_Z);
		r2 = longint'(ddx) * ddx + longint'(ddy) * ddy + longint'(ddz) * ddz;
		rec = '0;
		rec.dx = md_filter_pkg::dist_t'(ddx);
		rec.dy = md_filter_pkg::dist_t'(ddy);
		rec.dz = md_filter_pkg::dist_t'(ddz);
		rec.r2 = `R2_W'(r2);
		return (r2 <= `CUTOFF2) && (r2 > 0);
	endfunction

	task automatic check_value(input string name, input longint expected, input longint actual);
		if (expected != actual)
		begin
			errors++;
			$display("mismatch %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// Put one pair on a lane and queue it when the model says it passes
	task automatic drive_lane(input int lane, input logic v, input int rid, nid,
		input int rx, ry, rz, nx, ny, nz);
		md_filter_pkg::pair_rec_t rec;
		logic pass;
		pass = ref_pair(rx, ry, rz, nx, ny, nz, rec);
		rec.ref_id = md_filter_pkg::pair_id_t'(rid);
		rec.nbr_id = md_filter_pkg::pair_id_t'(nid);
		valid_in[lane]  = v;
		ref_id_in[lane] = rec.ref_id;
		nbr_id_in[lane] = rec.nbr_id;
		ref_c[lane][0]  = md_filter_pkg::coord_t'(rx);
		ref_c[lane][1]  = md_filter_pkg::coord_t'(ry);
		ref_c[lane][2]  = md_filter_pkg::coord_t'(rz);
		nbr_c[lane][0]  = md_filter_pkg::coord_t'(nx);
		nbr_c[lane][1]  = md_filter_pkg::coord_t'(ny);
		nbr_c[lane][2]  = md_filter_pkg::coord_t'(nz);
		if (v && pass)
			exp_q[lane].push_back(rec);
	endtask

	task automatic idle_lanes();
		valid_in[0] = 1'b0;
		valid_in[1] = 1'b0;
	endtask

	// One pair on one lane for a single cycle, the other lane quiet
	task automatic directed_pair(input int lane, rid, nid, input int rx, ry, rz, nx, ny, nz);
		step();
		idle_lanes();
		drive_lane(lane, 1'b1, rid, nid, rx, ry, rz, nx, ny, nz);
	endtask

	// Neighbor near the reference, sometimes across a face, sometimes the same spot
	task automatic random_lane(input int lane);
		int rx, ry, rz, nx, ny, nz;
		rx = int'($urandom % `BOX_X);
		ry = int'($urandom % `BOX_Y);
		rz = int'($urandom % `BOX_Z);
		nx = (rx + int'($urandom % 801) - 400 + `BOX_X) % `BOX_X;
		ny = (ry + int'($urandom % 801) - 400 + `BOX_Y) % `BOX_Y;
		nz = (rz + int'($urandom % 801) - 400 + `BOX_Z) % `BOX_Z;
		if ($urandom % 16 == 0)
			drive_lane(lane, 1'b1, $urandom, $urandom, rx, ry, rz, rx, ry, rz);
		else if (bp_out[lane] || $urandom % 4 == 0)
			drive_lane(lane, 1'b0, 0, 0, rx, ry, rz, nx, ny, nz);
		else
			drive_lane(lane, 1'b1, $urandom, $urandom, rx, ry, rz, nx, ny, nz);
		if (bp_out[lane])
			valid_in[lane] = 1'b0;
	endtask

	task automatic drain_pairs(input int max_cycles);
		int n;
		n = 0;
		while ((exp_q[0].size() + exp_q[1].size()) != 0 && n < max_cycles)
		begin
			step();
			n++;
		end
		if ((exp_q[0].size() + exp_q[1].size()) != 0)
		begin
			errors++;
			$display("%s: %0d expected pairs never came out", test_name,
				exp_q[0].size() + exp_q[1].size());
			exp_q[0].delete();
			exp_q[1].delete();
		end
		// Catch any stray output after the last expected pair
		repeat (10) step();
	endtask

	////////////////////////////////
	// Scoreboard
	////////////////////////////////
	// Sampled mid cycle, where inputs and buffer state are settled
	always @(negedge clk)
	begin
		if (!rst && out_valid && out_ready)
		begin
			both_pending = (exp_q[0].size() != 0) && (exp_q[1].size() != 0);
			if (exp_q[int'(out_lane)].size() == 0)
			begin
				errors++;
				$display("%s: lane %0d delivered a pair that was not expected",
					test_name, out_lane);
			end
			else
			begin
				head = exp_q[int'(out_lane)].pop_front();
				checked++;
				check_value({test_name, " ref_id"}, head.ref_id, out_ref_id);
				check_value({test_name, " nbr_id"}, head.nbr_id, out_nbr_id);
				check_value({test_name, " r2"}, head.r2, out_r2);
				check_value({test_name, " dx"}, head.dx, out_dx);
				check_value({test_name, " dy"}, head.dy, out_dy);
				check_value({test_name, " dz"}, head.dz, out_dz);
			end
			if (alt_mode && have_prev && both_pending)
				check_value({test_name, " alternation"}, !prev_lane, out_lane);
			prev_lane = out_lane;
			have_prev = alt_mode;
		end
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h2d5a_5763));
		errors = 0;
		checked = 0;
		alt_mode = 1'b0;
		have_prev = 1'b0;
		prev_lane = 1'b0;
		bp_seen[0] = 1'b0;
		bp_seen[1] = 1'b0;
		test_name = "reset";
		rst = 1'b1;
		out_ready = 1'b1;
		for (int l = 0; l < 2; l++)
			drive_lane(l, 1'b0, 0, 0, 0, 0, 0, 0, 0, 0);
		repeat (16) @(posedge clk);
		#1 rst = 1'b0;

		// Quiet outputs with no traffic
		repeat (10)
		begin
			step();
			check_value("idle out_valid", 0, out_valid);
			check_value("idle lane0_bp", 0, bp_out[0]);
			check_value("idle lane1_bp", 0, bp_out[1]);
		end

		// Face crossings, far pairs, self pairs and the exact cutoff
		test_name = "directed";
		directed_pair(0, 1, 2, 10, 100, 100, 2990, 100, 100);
		directed_pair(0, 3, 4, 50, 2400, 60, 50, 100, 60);
		directed_pair(1, 5, 6, 700, 700, 5, 700, 700, 2495);
		directed_pair(1, 7, 8, 0, 0, 0, 1000, 0, 0);
		directed_pair(0, 9, 9, 321, 654, 987, 321, 654, 987);
		directed_pair(0, 10, 11, 100, 200, 300, 600, 200, 300);
		directed_pair(1, 12, 13, 2800, 10, 10, 300, 10, 10);
		directed_pair(1, 14, 15, 100, 200, 300, 601, 200, 300);
		directed_pair(0, 16, 17, 2999, 2499, 2499, 1, 1, 1);
		step();
		idle_lanes();
		drain_pairs(100);

		// Both lanes at once, output always ready
		test_name = "random";
		for (int i = 0; i < N_RAND; i++)
		begin
			step();
			random_lane(0);
			random_lane(1);
		end
		step();
		idle_lanes();
		drain_pairs(2000);

		// Stalled output, sources honor bp
		test_name = "backpressure";
		out_ready = 1'b0;
		for (int i = 0; i < N_BP; i++)
		begin
			step();
			bp_seen[0] = bp_seen[0] | bp_out[0];
			bp_seen[1] = bp_seen[1] | bp_out[1];
			random_lane(0);
			random_lane(1);
		end
		step();
		idle_lanes();
		check_value("backpressure lane0_bp rose", 1, bp_seen[0]);
		check_value("backpressure lane1_bp rose", 1, bp_seen[1]);
		// Let pairs in flight settle into the buffers before release
		repeat (8) step();
		test_name = "alternation";
		alt_mode = 1'b1;
		have_prev = 1'b0;
		out_ready = 1'b1;
		drain_pairs(500);
		alt_mode = 1'b0;

		$display("Errors: %0d, pairs checked: %0d", errors, checked);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+common
common/md_filter_pkg.sv
common/pair_if.sv
filter/r2_pbc_compute.sv
filter/pair_buffer.sv
filter/pair_filter.sv
logic/pair_arbiter.sv
logic/md_filter_bank.sv
tb/md_filter_bank_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= md_filter_bank_tb
FILELIST  ?= sim.f
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
